//--- logic/seg_pkg.sv
// segment and beat types
`default_nettype none

package seg_pkg;

   localparam int SEG_DATA_W = 64;
   localparam int SEG_KEEP_W = SEG_DATA_W/8;
   localparam int TID_W      = 3;
   localparam int MD_W       = 8;

   // output beats per packet marked as header
   localparam int HDR_BEATS  = 2;
   // slots kept free below full before ingress ready drops
   localparam int WM_MARGIN  = 4;

   // one 64-bit segment with its sideband
   typedef struct packed {
      logic [SEG_DATA_W-1:0] data;
      logic [SEG_KEEP_W-1:0] keep;
      logic [TID_W-1:0]      tid;
      logic                  err;
      logic                  last_seg;
   } seg_t;

   // ingress beat as stored in the FIFO
   typedef struct packed {
      seg_t            seg;
      logic            tlast;
      logic [MD_W-1:0] md;
   } igr_beat_t;

   typedef struct packed {
      logic sop;
      logic eop;
      logic hdr_segment;
      logic payld_segment;
   } seg_info_t;

endpackage

`default_nettype wire

//--- logic/csr_pkg.sv
// register map and bus widths
`default_nettype none

package csr_pkg;

   localparam int CSR_ADDR_W = 8;
   localparam int CSR_DATA_W = 32;

   // word addresses
   localparam logic [CSR_ADDR_W-1:0] ADDR_PAUSE_EN  = 8'h00;
   localparam logic [CSR_ADDR_W-1:0] ADDR_PAUSE_THR = 8'h01;
   // read only
   localparam logic [CSR_ADDR_W-1:0] ADDR_FIFO_LVL  = 8'h02;

   typedef struct packed {
      logic        pause_en;
      logic [15:0] pause_thr;
   } cfg_t;

endpackage

`default_nettype wire

//--- logic/seg_fifo.sv
// ingress beat FIFO
`timescale 1ns/1ps
`default_nettype none

module seg_fifo
  #(parameter int FIFO_DEPTH = 64
   )
   (
    input  var logic                        clk
   ,input  var logic                        rst
   ,input  var logic                        push_i
   ,input  var seg_pkg::igr_beat_t          wdata_i
   ,input  var logic                        pop_i
   ,output var seg_pkg::igr_beat_t          rdata_o
   ,output var logic                        empty_o
   ,output var logic [$clog2(FIFO_DEPTH):0] level_o
   );
   import seg_pkg::*;

   localparam int AW = $clog2(FIFO_DEPTH);

   igr_beat_t mem [FIFO_DEPTH];

   logic [AW:0] wr_ptr_q;
   logic [AW:0] rd_ptr_q;
   // write pointer as seen by the read side, one cycle behind
   logic [AW:0] wr_vis_q;

   always_ff @(posedge clk) begin
      if (push_i) begin
         mem[wr_ptr_q[AW-1:0]] <= wdata_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         wr_vis_q <= '0;
      end else begin
         wr_vis_q <= wr_ptr_q;
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_i && !empty_o) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // show-ahead head entry and stored count
   always_comb begin
      empty_o = (rd_ptr_q == wr_vis_q);
      rdata_o = mem[rd_ptr_q[AW-1:0]];
      level_o = wr_ptr_q - rd_ptr_q;
   end

endmodule

`default_nettype wire

//--- logic/seg_gather_ctrl.sv
// segment gather control
`timescale 1ns/1ps
`default_nettype none

module seg_gather_ctrl
  #(parameter int ENUM_SEG = 4
   )
   (
    input  var logic                     clk
   ,input  var logic                     rst
   ,input  var seg_pkg::igr_beat_t       head_i
   ,input  var logic                     empty_i
   ,input  var logic                     load_ready_i
   ,output var logic                     pop_o
   ,output var seg_pkg::seg_t            seg_o
   ,output var logic [ENUM_SEG-1:0]      lane_we_o
   ,output var logic                     start_o
   ,output var logic                     close_o
   ,output var logic [seg_pkg::MD_W-1:0] sop_md_o
   ,output var logic                     tlast_o
   );
   import seg_pkg::*;

   localparam int CNT_W = (ENUM_SEG > 1) ? $clog2(ENUM_SEG) : 1;
   localparam logic [CNT_W-1:0] LAST_LANE = CNT_W'(ENUM_SEG-1);

   logic [CNT_W-1:0] lane_cnt_q;
   logic             first_q;
   logic             pend_q;
   logic             closing;
   logic [MD_W-1:0]  md_q;
   logic             tlast_q;

   //----------------------------------------------------------------------
   // pop and lane steering
   //----------------------------------------------------------------------
   always_comb begin
      // a closed beat still waiting blocks further pops
      pop_o     = !empty_i && (!pend_q || load_ready_i);
      closing   = pop_o && ((lane_cnt_q == LAST_LANE) || head_i.tlast);
      lane_we_o = pop_o ? (ENUM_SEG'(1) << lane_cnt_q) : '0;
      start_o   = pop_o && (lane_cnt_q == '0);
      close_o   = pend_q && load_ready_i;
      seg_o     = head_i.seg;
      sop_md_o  = md_q;
      tlast_o   = tlast_q;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         lane_cnt_q <= '0;
         first_q    <= 1'b1;
         pend_q     <= 1'b0;
      end else begin
         if (closing) begin
            lane_cnt_q <= '0;
         end else if (pop_o) begin
            lane_cnt_q <= lane_cnt_q + 1'b1;
         end
         if (pop_o) begin
            first_q <= head_i.tlast;
         end
         if (closing) begin
            pend_q <= 1'b1;
         end else if (load_ready_i) begin
            pend_q <= 1'b0;
         end
      end
   end

   // metadata of the packet's first beat, tlast of the closing beat
   always_ff @(posedge clk) begin
      if (pop_o && first_q) begin
         md_q <= head_i.md;
      end
      if (closing) begin
         tlast_q <= head_i.tlast;
      end
   end

endmodule

`default_nettype wire

//--- logic/seg_lane.sv
// egress segment slot
`timescale 1ns/1ps
`default_nettype none

module seg_lane
   (
    input  var logic          clk
   ,input  var logic          rst
   ,input  var logic          we_i
   ,input  var logic          clear_i
   ,input  var seg_pkg::seg_t seg_i
   ,output var seg_pkg::seg_t seg_o
   );
   import seg_pkg::*;

   seg_t seg_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         seg_q <= '0;
      end else if (we_i) begin
         seg_q <= seg_i;
      end else if (clear_i) begin
         // empty slot of a new beat, tid left as is
         seg_q.data     <= '0;
         seg_q.keep     <= '0;
         seg_q.err      <= 1'b0;
         seg_q.last_seg <= 1'b0;
      end
   end

   assign seg_o = seg_q;

endmodule

`default_nettype wire

//--- logic/beat_emit.sv
// egress beat register
`timescale 1ns/1ps
`default_nettype none

module beat_emit
  #(parameter int ENUM_SEG    = 4
   ,parameter int BYTE_ROTATE = 0
   )
   (
    input  var logic                                           clk
   ,input  var logic                                           rst
   ,input  var logic                                           close_i
   ,input  var seg_pkg::seg_t [ENUM_SEG-1:0]                   lanes_i
   ,input  var logic [seg_pkg::MD_W-1:0]                       md_i
   ,input  var logic                                           tlast_i
   ,input  var logic                                           trdy_i
   ,output var logic                                           load_ready_o
   ,output var logic                                           tvld_o
   ,output var logic [ENUM_SEG-1:0][seg_pkg::SEG_DATA_W-1:0]   tdata_o
   ,output var logic [ENUM_SEG-1:0][seg_pkg::SEG_KEEP_W-1:0]   tkeep_o
   ,output var logic [ENUM_SEG-1:0][seg_pkg::TID_W-1:0]        tid_o
   ,output var logic [ENUM_SEG-1:0]                            terr_o
   ,output var logic [ENUM_SEG-1:0]                            tlast_segment_o
   ,output var logic                                           tlast_o
   ,output var logic [seg_pkg::MD_W-1:0]                       tuser_md_o
   ,output var seg_pkg::seg_info_t                             seg_info_o
   );
   import seg_pkg::*;

   localparam int NBYTES = ENUM_SEG*SEG_KEEP_W;
   localparam int CNT_W  = $clog2(HDR_BEATS+1);

   logic                 vld_q;
   logic                 accept;
   seg_t [ENUM_SEG-1:0]  beat_q;
   logic                 tlast_q;
   logic [MD_W-1:0]      md_q;
   logic [CNT_W-1:0]     beat_cnt_q;
   logic [NBYTES-1:0][7:0] word_b;
   logic [NBYTES-1:0][7:0] rot_b;

   assign accept       = vld_q && trdy_i;
   assign load_ready_o = !vld_q || trdy_i;

   //----------------------------------------------------------------------
   // output register, held while trdy_i is low
   //----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         vld_q <= 1'b0;
      end else if (close_i) begin
         vld_q <= 1'b1;
      end else if (trdy_i) begin
         vld_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (close_i) begin
         beat_q  <= lanes_i;
         tlast_q <= tlast_i;
         md_q    <= md_i;
      end
   end

   // accepted beats within the packet, saturating past the header
   always_ff @(posedge clk) begin
      if (rst) begin
         beat_cnt_q <= '0;
      end else if (accept) begin
         if (tlast_q) begin
            beat_cnt_q <= '0;
         end else if (beat_cnt_q != CNT_W'(HDR_BEATS)) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
         end
      end
   end

   //----------------------------------------------------------------------
   // egress outputs
   //----------------------------------------------------------------------
   always_comb begin
      for (int i = 0; i < ENUM_SEG; i++) begin
         word_b[i*SEG_KEEP_W +: SEG_KEEP_W] = beat_q[i].data;
         tkeep_o[i]         = beat_q[i].keep;
         tid_o[i]           = beat_q[i].tid;
         terr_o[i]          = beat_q[i].err;
         tlast_segment_o[i] = beat_q[i].last_seg;
      end
      // msb byte of the whole word goes to lsb
      for (int b = 0; b < NBYTES; b++) begin
         rot_b[b] = word_b[NBYTES-1-b];
      end
      tdata_o    = (BYTE_ROTATE != 0) ? rot_b : word_b;
      tvld_o     = vld_q;
      tlast_o    = tlast_q;
      tuser_md_o = md_q;

      seg_info_o.sop           = (beat_cnt_q == '0);
      seg_info_o.eop           = tlast_q;
      seg_info_o.hdr_segment   = (beat_cnt_q < CNT_W'(HDR_BEATS));
      seg_info_o.payld_segment = !(beat_cnt_q < CNT_W'(HDR_BEATS));
   end

endmodule

`default_nettype wire

//--- logic/wadj_csr.sv
// configuration registers
`timescale 1ns/1ps
`default_nettype none

module wadj_csr
   (
    input  var logic                             clk
   ,input  var logic                             rst
   ,input  var logic [csr_pkg::CSR_ADDR_W-1:0]   csr_addr_i
   ,input  var logic                             csr_read_i
   ,input  var logic                             csr_write_i
   ,input  var logic [csr_pkg::CSR_DATA_W-1:0]   csr_wdata_i
   ,input  var logic [csr_pkg::CSR_DATA_W/8-1:0] csr_byteen_i
   ,input  var logic [15:0]                      level_i
   ,output var logic [csr_pkg::CSR_DATA_W-1:0]   csr_rdata_o
   ,output var logic                             csr_readdata_valid_o
   ,output var logic                             rx_pause_o
   );
   import csr_pkg::*;

   cfg_t                  cfg_q;
   logic [CSR_DATA_W-1:0] rdata_nxt;
   logic [CSR_DATA_W-1:0] rdata_q;
   logic                  rvalid_q;
   logic                  pause_q;

   //----------------------------------------------------------------------
   // register writes, per byte lane
   //----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         cfg_q <= '0;
      end else if (csr_write_i) begin
         if (csr_addr_i == ADDR_PAUSE_EN && csr_byteen_i[0]) begin
            cfg_q.pause_en <= csr_wdata_i[0];
         end
         if (csr_addr_i == ADDR_PAUSE_THR) begin
            if (csr_byteen_i[0]) begin
               cfg_q.pause_thr[7:0] <= csr_wdata_i[7:0];
            end
            if (csr_byteen_i[1]) begin
               cfg_q.pause_thr[15:8] <= csr_wdata_i[15:8];
            end
         end
      end
   end

   // read mux, unmapped addresses return zero
   always_comb begin
      rdata_nxt = '0;
      case (csr_addr_i)
         ADDR_PAUSE_EN:  rdata_nxt[0]    = cfg_q.pause_en;
         ADDR_PAUSE_THR: rdata_nxt[15:0] = cfg_q.pause_thr;
         ADDR_FIFO_LVL:  rdata_nxt[15:0] = level_i;
         default:        rdata_nxt       = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rvalid_q <= 1'b0;
         pause_q  <= 1'b0;
      end else begin
         rvalid_q <= csr_read_i;
         pause_q  <= cfg_q.pause_en && (level_i > cfg_q.pause_thr);
      end
      if (csr_read_i) begin
         rdata_q <= rdata_nxt;
      end
   end

   assign csr_rdata_o          = rdata_q;
   assign csr_readdata_valid_o = rvalid_q;
   assign rx_pause_o           = pause_q;

endmodule

`default_nettype wire

//--- logic/rx_wadj_top.sv
// ingress width adjuster
`timescale 1ns/1ps
`default_nettype none

module rx_wadj_top
  #(parameter int ENUM_SEG    = 8
   ,parameter int FIFO_DEPTH  = 64
   ,parameter int BYTE_ROTATE = 0
   )
   (
    input  var logic                                         clk
   ,input  var logic                                         rst

   // ingress, one segment per beat
   ,input  var logic                                         tvld_i
   ,input  var seg_pkg::igr_beat_t                           igr_beat_i
   ,output var logic                                         trdy_o

   // egress, ENUM_SEG segments per beat
   ,input  var logic                                         trdy_i
   ,output var logic                                         tvld_o
   ,output var logic [ENUM_SEG-1:0][seg_pkg::SEG_DATA_W-1:0] tdata_o
   ,output var logic [ENUM_SEG-1:0][seg_pkg::SEG_KEEP_W-1:0] tkeep_o
   ,output var logic [ENUM_SEG-1:0][seg_pkg::TID_W-1:0]      tid_o
   ,output var logic [ENUM_SEG-1:0]                          terr_o
   ,output var logic [ENUM_SEG-1:0]                          tlast_segment_o
   ,output var logic                                         tlast_o
   ,output var logic [seg_pkg::MD_W-1:0]                     tuser_md_o
   ,output var seg_pkg::seg_info_t                           seg_info_o

   // register port
   ,input  var logic [csr_pkg::CSR_ADDR_W-1:0]               csr_addr_i
   ,input  var logic                                         csr_read_i
   ,input  var logic                                         csr_write_i
   ,input  var logic [csr_pkg::CSR_DATA_W-1:0]               csr_wdata_i
   ,input  var logic [csr_pkg::CSR_DATA_W/8-1:0]             csr_byteen_i
   ,output var logic [csr_pkg::CSR_DATA_W-1:0]               csr_rdata_o
   ,output var logic                                         csr_readdata_valid_o
   ,output var logic                                         rx_pause_o
   );
   import seg_pkg::*;

   localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;
   localparam logic [LVL_W-1:0] RDY_WM = LVL_W'(FIFO_DEPTH - WM_MARGIN);

   igr_beat_t           fifo_head;
   logic                fifo_empty;
   logic                fifo_pop;
   logic [LVL_W-1:0]    fifo_level;
   logic                push;
   seg_t                gather_seg;
   logic [ENUM_SEG-1:0] lane_we;
   logic                lane_start;
   logic                close;
   logic [MD_W-1:0]     sop_md;
   logic                close_tlast;
   logic                load_ready;
   seg_t [ENUM_SEG-1:0] lanes;

   //----------------------------------------------------------------------
   // ingress ready from the FIFO watermark
   //----------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         trdy_o <= 1'b0;
      end else begin
         trdy_o <= (fifo_level < RDY_WM);
      end
   end

   assign push = tvld_i && trdy_o;

   seg_fifo #(.FIFO_DEPTH (FIFO_DEPTH)) u_fifo
     (.clk     (clk)
     ,.rst     (rst)
     ,.push_i  (push)
     ,.wdata_i (igr_beat_i)
     ,.pop_i   (fifo_pop)
     ,.rdata_o (fifo_head)
     ,.empty_o (fifo_empty)
     ,.level_o (fifo_level)
     );

   seg_gather_ctrl #(.ENUM_SEG (ENUM_SEG)) u_gather
     (.clk          (clk)
     ,.rst          (rst)
     ,.head_i       (fifo_head)
     ,.empty_i      (fifo_empty)
     ,.load_ready_i (load_ready)
     ,.pop_o        (fifo_pop)
     ,.seg_o        (gather_seg)
     ,.lane_we_o    (lane_we)
     ,.start_o      (lane_start)
     ,.close_o      (close)
     ,.sop_md_o     (sop_md)
     ,.tlast_o      (close_tlast)
     );

   // packing buffer
   for (genvar i = 0; i < ENUM_SEG; i++) begin : g_lane
      seg_lane u_lane
        (.clk     (clk)
        ,.rst     (rst)
        ,.we_i    (lane_we[i])
        ,.clear_i (lane_start)
        ,.seg_i   (gather_seg)
        ,.seg_o   (lanes[i])
        );
   end

   beat_emit #(.ENUM_SEG (ENUM_SEG), .BYTE_ROTATE (BYTE_ROTATE)) u_emit
     (.clk             (clk)
     ,.rst             (rst)
     ,.close_i         (close)
     ,.lanes_i         (lanes)
     ,.md_i            (sop_md)
     ,.tlast_i         (close_tlast)
     ,.trdy_i          (trdy_i)
     ,.load_ready_o    (load_ready)
     ,.tvld_o          (tvld_o)
     ,.tdata_o         (tdata_o)
     ,.tkeep_o         (tkeep_o)
     ,.tid_o           (tid_o)
     ,.terr_o          (terr_o)
     ,.tlast_segment_o (tlast_segment_o)
     ,.tlast_o         (tlast_o)
     ,.tuser_md_o      (tuser_md_o)
     ,.seg_info_o      (seg_info_o)
     );

   wadj_csr u_csr
     (.clk                  (clk)
     ,.rst                  (rst)
     ,.csr_addr_i           (csr_addr_i)
     ,.csr_read_i           (csr_read_i)
     ,.csr_write_i          (csr_write_i)
     ,.csr_wdata_i          (csr_wdata_i)
     ,.csr_byteen_i         (csr_byteen_i)
     ,.level_i              (16'(fifo_level))
     ,.csr_rdata_o          (csr_rdata_o)
     ,.csr_readdata_valid_o (csr_readdata_valid_o)
     ,.rx_pause_o           (rx_pause_o)
     );

endmodule

`default_nettype wire

//--- verif/rx_wadj_tb.sv
// width adjuster testbench
`timescale 1ns/1ps
`default_nettype none

module rx_wadj_tb;
   import seg_pkg::*;
   import csr_pkg::*;

   localparam int NSEG        = 4;
   localparam int FIFO_DEPTH  = 32;
   localparam int BYTE_ROT    = 1;
   localparam int HALF_PERIOD = 50;
   localparam int NRAND       = 24;
   localparam int FILL_LEN    = 48;
   localparam int REG_CYCLES  = 200;
   localparam int WORD_W      = NSEG*SEG_DATA_W;

   // one predicted egress beat
   typedef struct packed {
      logic [WORD_W-1:0]          data;
      logic [NSEG*SEG_KEEP_W-1:0] keep;
      logic [NSEG*TID_W-1:0]      tid;
      logic [NSEG*TID_W-1:0]      tid_mask;
      logic [NSEG-1:0]            err;
      logic [NSEG-1:0]            lseg;
      logic                       tlast;
      logic [MD_W-1:0]            md;
      seg_info_t                  info;
   } exp_beat_t;

   logic clk = 1'b0;
   logic rst = 1'b1;
   logic tvld_i;
   igr_beat_t igr_beat_i;
   logic trdy_o;
   logic trdy_i = 1'b0;
   logic tvld_o;
   logic [NSEG-1:0][SEG_DATA_W-1:0] tdata_o;
   logic [NSEG-1:0][SEG_KEEP_W-1:0] tkeep_o;
   logic [NSEG-1:0][TID_W-1:0] tid_o;
   logic [NSEG-1:0] terr_o;
   logic [NSEG-1:0] tlast_segment_o;
   logic tlast_o;
   logic [MD_W-1:0] tuser_md_o;
   seg_info_t seg_info_o;
   logic [CSR_ADDR_W-1:0] csr_addr_i;
   logic csr_read_i;
   logic csr_write_i;
   logic [CSR_DATA_W-1:0] csr_wdata_i;
   logic [CSR_DATA_W/8-1:0] csr_byteen_i;
   logic [CSR_DATA_W-1:0] csr_rdata_o;
   logic csr_readdata_valid_o;
   logic rx_pause_o;

   logic [31:0] lfsr_q = 32'h0a141e14;
   int          rdy_mode = 0;
   logic        rdy_rand = 1'b0;
   int          errors = 0;
   int          beats_checked = 0;
   int          acc_cnt = 0;
   int          edge_cnt = 0;
   int          total_beats = 0;
   logic        plan_done = 1'b0;
   int          rand_len [NRAND];

   // reference model state
   exp_beat_t   exp_q [$];
   exp_beat_t   bld = '0;
   logic [WORD_W-1:0] raw_word = '0;
   int          bld_n = 0;
   int          out_idx = 0;
   logic        pkt_first = 1'b1;
   logic [MD_W-1:0] pkt_md = '0;

   rx_wadj_top #(.ENUM_SEG (NSEG), .FIFO_DEPTH (FIFO_DEPTH), .BYTE_ROTATE (BYTE_ROT))
      rx_wadj_top_i
     (.clk (clk), .rst (rst)
     ,.tvld_i (tvld_i), .igr_beat_i (igr_beat_i), .trdy_o (trdy_o)
     ,.trdy_i (trdy_i), .tvld_o (tvld_o), .tdata_o (tdata_o), .tkeep_o (tkeep_o)
     ,.tid_o (tid_o), .terr_o (terr_o), .tlast_segment_o (tlast_segment_o)
     ,.tlast_o (tlast_o), .tuser_md_o (tuser_md_o), .seg_info_o (seg_info_o)
     ,.csr_addr_i (csr_addr_i), .csr_read_i (csr_read_i), .csr_write_i (csr_write_i)
     ,.csr_wdata_i (csr_wdata_i), .csr_byteen_i (csr_byteen_i)
     ,.csr_rdata_o (csr_rdata_o), .csr_readdata_valid_o (csr_readdata_valid_o)
     ,.rx_pause_o (rx_pause_o)
     );

   always #HALF_PERIOD clk = ~clk;

   // fibonacci lfsr over x^32+x^22+x^2+x+1 stepped once per bit
   function logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   function igr_beat_t make_beat(input int idx, input int len);
      igr_beat_t   b;
      logic [31:0] r;
      b.seg.data = {rand_bits(32), rand_bits(32)};
      r = rand_bits(8);
      b.seg.keep = r[7:0];
      r = rand_bits(3);
      b.seg.tid = r[2:0];
      r = rand_bits(1);
      b.seg.err = r[0];
      b.seg.last_seg = (idx == len-1);
      b.tlast = (idx == len-1);
      // every beat gets its own md but only the first one may show up
      r = rand_bits(8);
      b.md = r[7:0];
      return b;
   endfunction

   // whole-word byte order swap
   function logic [WORD_W-1:0] byte_reverse(input logic [WORD_W-1:0] w);
      logic [WORD_W-1:0] r;
      for (int b = 0; b < WORD_W/8; b++) begin
         r[b*8 +: 8] = w[(WORD_W/8-1-b)*8 +: 8];
      end
      return r;
   endfunction

   //----------------------------------------------------------------------
   // egress ready mode 0 holds it low, 1 holds it high and 2 draws it
   //----------------------------------------------------------------------
   always @(posedge clk) begin
      if (rdy_mode == 1) begin
         trdy_i <= 1'b1;
      end else if (rdy_mode == 2) begin
         trdy_i <= rdy_rand;
      end else begin
         trdy_i <= 1'b0;
      end
   end

   // random ready bit for the next rising edge
   always @(negedge clk) begin
      if (rdy_mode == 2) begin
         rdy_rand = (rand_bits(1) != 0);
      end
   end

   // packs accepted ingress beats into predicted egress beats
   always @(posedge clk) begin : ingress_model
      if (!rst && tvld_i && trdy_o) begin
         acc_cnt++;
         if (pkt_first) begin
            pkt_md = igr_beat_i.md;
         end
         raw_word[bld_n*SEG_DATA_W +: SEG_DATA_W] = igr_beat_i.seg.data;
         bld.keep[bld_n*SEG_KEEP_W +: SEG_KEEP_W] = igr_beat_i.seg.keep;
         bld.tid[bld_n*TID_W +: TID_W]            = igr_beat_i.seg.tid;
         bld.tid_mask[bld_n*TID_W +: TID_W]       = '1;
         bld.err[bld_n]  = igr_beat_i.seg.err;
         bld.lseg[bld_n] = igr_beat_i.seg.last_seg;
         bld_n++;
         pkt_first = igr_beat_i.tlast;
         if (bld_n == NSEG || igr_beat_i.tlast) begin
            bld.data  = (BYTE_ROT != 0) ? byte_reverse(raw_word) : raw_word;
            bld.tlast = igr_beat_i.tlast;
            bld.md    = pkt_md;
            bld.info.sop           = (out_idx == 0);
            bld.info.eop           = igr_beat_i.tlast;
            bld.info.hdr_segment   = (out_idx < HDR_BEATS);
            bld.info.payld_segment = (out_idx >= HDR_BEATS);
            exp_q.push_back(bld);
            out_idx = igr_beat_i.tlast ? 0 : out_idx + 1;
            bld_n = 0;
            bld = '0;
            raw_word = '0;
         end
      end
   end

   //----------------------------------------------------------------------
   // checks
   //----------------------------------------------------------------------
   always @(posedge clk) begin : egress_check
      exp_beat_t e;
      if (!rst && tvld_o && trdy_i) begin
         assert (exp_q.size() != 0) else begin
            errors++;
            $display("egress beat at %0t has no ingress data to match", $time);
         end
         if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            beats_checked++;
            assert (tdata_o == e.data) else begin
               errors++;
               $display("mismatch at %0t: tdata exp %h got %h", $time, e.data, tdata_o);
            end
            assert (tkeep_o == e.keep && terr_o == e.err && tlast_segment_o == e.lseg)
            else begin
               errors++;
               $display("mismatch at %0t: keep/err/last_seg exp %h/%b/%b got %h/%b/%b",
                        $time, e.keep, e.err, e.lseg, tkeep_o, terr_o, tlast_segment_o);
            end
            assert ((tid_o & e.tid_mask) == e.tid) else begin
               errors++;
               $display("mismatch at %0t: tid exp %h got %h", $time, e.tid, tid_o);
            end
            assert (tlast_o == e.tlast && tuser_md_o == e.md) else begin
               errors++;
               $display("mismatch at %0t: tlast/md exp %b/%h got %b/%h",
                        $time, e.tlast, e.md, tlast_o, tuser_md_o);
            end
            assert (seg_info_o == e.info) else begin
               errors++;
               $display("mismatch at %0t: seg_info exp %b got %b", $time, e.info, seg_info_o);
            end
         end
      end
   end

   // edges 2 to 5 fall in reset and edge 6 samples the cycle after
   always @(posedge clk) begin : reset_check
      edge_cnt++;
      if (edge_cnt >= 2 && edge_cnt <= 6) begin
         assert (!trdy_o && !tvld_o && !rx_pause_o && !csr_readdata_valid_o) else begin
            errors++;
            $display("mismatch at %0t: outputs not low around reset", $time);
         end
      end
   end

   hold_stable: assert property (@(posedge clk) disable iff (rst)
      (tvld_o && !trdy_i) |=> (tvld_o && $stable(tdata_o) && $stable(tkeep_o)
         && $stable(tid_o) && $stable(terr_o) && $stable(tlast_segment_o)
         && $stable(tlast_o) && $stable(tuser_md_o) && $stable(seg_info_o)))
   else begin
      errors++;
      $display("mismatch at %0t: egress changed while stalled", $time);
   end

   //----------------------------------------------------------------------
   // stimulus tasks
   //----------------------------------------------------------------------
   task send_beat(input igr_beat_t b);
      tvld_i     <= 1'b1;
      igr_beat_i <= b;
      do @(posedge clk); while (!trdy_o);
   endtask

   task send_pkt(input int len);
      for (int i = 0; i < len; i++) begin
         send_beat(make_beat(i, len));
      end
      tvld_i <= 1'b0;
   endtask

   task drain();
      while (exp_q.size() != 0) @(posedge clk);
      repeat (4) @(posedge clk);
   endtask

   task csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [CSR_DATA_W-1:0] data,
                  input logic [CSR_DATA_W/8-1:0] be);
      @(posedge clk);
      csr_addr_i   <= addr;
      csr_wdata_i  <= data;
      csr_byteen_i <= be;
      csr_write_i  <= 1'b1;
      @(posedge clk);
      csr_write_i  <= 1'b0;
   endtask

   // read data must be valid exactly one cycle after the read
   task check_reg(input logic [CSR_ADDR_W-1:0] addr, input logic [CSR_DATA_W-1:0] exp);
      @(posedge clk);
      csr_addr_i <= addr;
      csr_read_i <= 1'b1;
      @(posedge clk);
      csr_read_i <= 1'b0;
      @(posedge clk);
      assert (csr_readdata_valid_o && csr_rdata_o == exp) else begin
         errors++;
         $display("mismatch at %0t: reg %0d exp %h got %h valid %b",
                  $time, addr, exp, csr_rdata_o, csr_readdata_valid_o);
      end
   endtask

   initial begin : watchdog
      wait (plan_done);
      repeat (total_beats*20 + REG_CYCLES) @(posedge clk);
      $display("timeout: the run did not finish in time, %0d beats still expected",
               exp_q.size());
      $display("=== FAIL ===");
      $finish;
   end

   initial begin : main
      igr_beat_t hb;
      int        fill_acc;
      int        stall;
      tvld_i       = 1'b0;
      igr_beat_i   = '0;
      csr_addr_i   = '0;
      csr_read_i   = 1'b0;
      csr_write_i  = 1'b0;
      csr_wdata_i  = '0;
      csr_byteen_i = '0;
      for (int k = 0; k < NRAND; k++) begin
         rand_len[k] = 1 + int'(rand_bits(4));
         total_beats += rand_len[k];
      end
      total_beats += 8 + 1 + 3 + 6 + 12 + FILL_LEN;
      plan_done = 1'b1;

      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      // directed packets with egress always ready
      rdy_mode <= 1;
      send_pkt(8);
      send_pkt(1);
      send_pkt(3);
      send_pkt(6);
      send_pkt(12);
      drain();

      // ---------------------------------------------------------------
      // fill the FIFO with egress stalled
      rdy_mode <= 0;
      repeat (2) @(posedge clk);
      csr_write(ADDR_PAUSE_THR, 32'h0000_0014, 4'b1111);
      fill_acc = 0;
      stall = 0;
      hb = make_beat(0, FILL_LEN);
      tvld_i     <= 1'b1;
      igr_beat_i <= hb;
      while (stall < 6) begin
         @(posedge clk);
         if (trdy_o) begin
            fill_acc++;
            stall = 0;
            hb = make_beat(fill_acc, FILL_LEN);
            igr_beat_i <= hb;
         end else begin
            stall++;
         end
      end
      // one beat sits in the output register and one more in the lanes
      // registered ready lets one more beat in past the watermark
      assert (fill_acc - 2*NSEG == FIFO_DEPTH - WM_MARGIN + 1) else begin
         errors++;
         $display("mismatch at %0t: ingress ready fell at level %0d", $time,
                  fill_acc - 2*NSEG);
      end
      check_reg(ADDR_FIFO_LVL, 32'(fill_acc - 2*NSEG));

      // register access while the ingress beat is held
      csr_write(ADDR_PAUSE_THR, 32'h0000_1234, 4'b0011);
      check_reg(ADDR_PAUSE_THR, 32'h0000_1234);
      csr_write(ADDR_PAUSE_THR, 32'h0000_5614, 4'b0001);
      check_reg(ADDR_PAUSE_THR, 32'h0000_1214);
      check_reg(8'h07, 32'h0);
      csr_write(ADDR_PAUSE_THR, 32'h0000_0014, 4'b1111);
      repeat (2) @(posedge clk);
      assert (!rx_pause_o) else begin
         errors++;
         $display("mismatch at %0t: pause raised with enable cleared", $time);
      end
      // a threshold equal to the level is not exceeded
      csr_write(ADDR_PAUSE_THR, 32'(fill_acc - 2*NSEG), 4'b1111);
      csr_write(ADDR_PAUSE_EN, 32'h1, 4'b0001);
      repeat (2) @(posedge clk);
      assert (!rx_pause_o) else begin
         errors++;
         $display("mismatch at %0t: pause raised with level equal to threshold", $time);
      end
      csr_write(ADDR_PAUSE_THR, 32'(fill_acc - 2*NSEG - 1), 4'b1111);
      repeat (2) @(posedge clk);
      assert (rx_pause_o) else begin
         errors++;
         $display("mismatch at %0t: pause low with level above threshold", $time);
      end
      csr_write(ADDR_PAUSE_EN, 32'h0, 4'b0001);
      repeat (2) @(posedge clk);
      assert (!rx_pause_o) else begin
         errors++;
         $display("mismatch at %0t: pause stuck after enable cleared", $time);
      end

      // release egress at random and finish the held packet
      rdy_mode <= 2;
      send_beat(hb);
      for (int j = fill_acc + 1; j < FILL_LEN; j++) begin
         send_beat(make_beat(j, FILL_LEN));
      end
      tvld_i <= 1'b0;

      for (int k = 0; k < NRAND; k++) begin
         send_pkt(rand_len[k]);
      end
      drain();
      repeat (10) @(posedge clk);

      $display("errors: %0d, egress beats checked: %0d, ingress beats sent: %0d",
               errors, beats_checked, acc_cnt);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
logic/seg_pkg.sv
logic/csr_pkg.sv
logic/seg_fifo.sv
logic/seg_gather_ctrl.sv
logic/seg_lane.sv
logic/beat_emit.sv
logic/wadj_csr.sv
logic/rx_wadj_top.sv
verif/rx_wadj_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the width adjuster simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f src.f \
   --top-module rx_wadj_tb \
   -Mdir obj_dir \
   -o rx_wadj_sim

./obj_dir/rx_wadj_sim > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation finished without failure"
exit 0
